//--- src/debug_pkg.sv
package debug_pkg;

	localparam int IR_W        = 5;
	localparam int DR_W        = 32;
	localparam int GAIN_W      = 4;
	localparam int PI_CTL_W    = 8;
	localparam int RST_TARGETS = 6;

	typedef logic [IR_W-1:0]     ir_t;
	typedef logic [DR_W-1:0]     dr_t;
	typedef logic [GAIN_W-1:0]   gain_t;
	typedef logic [PI_CTL_W-1:0] pi_ctl_t;

	// instruction codes, unknown codes select bypass
	localparam ir_t IR_IDCODE   = 5'd1;
	localparam ir_t IR_CFG_CDR  = 5'd2;
	localparam ir_t IR_CFG_IBUF = 5'd3;
	localparam ir_t IR_RSTB_CMD = 5'd4;
	localparam ir_t IR_STATUS   = 5'd5;
	localparam ir_t IR_BYPASS   = 5'h1f;

	localparam dr_t IDCODE_VALUE = 32'h1A5C_0001;

	// IEEE 1149.1 state encoding
	typedef enum logic [3:0] {
		TAP_EXIT2_DR = 4'h0,
		TAP_EXIT1_DR = 4'h1,
		TAP_SHIFT_DR = 4'h2,
		TAP_PAUSE_DR = 4'h3,
		TAP_SEL_IR   = 4'h4,
		TAP_UPD_DR   = 4'h5,
		TAP_CAP_DR   = 4'h6,
		TAP_SEL_DR   = 4'h7,
		TAP_EXIT2_IR = 4'h8,
		TAP_EXIT1_IR = 4'h9,
		TAP_SHIFT_IR = 4'hA,
		TAP_PAUSE_IR = 4'hB,
		TAP_RTI      = 4'hC,
		TAP_UPD_IR   = 4'hD,
		TAP_CAP_IR   = 4'hE,
		TAP_TLR      = 4'hF
	} tap_state_t;

	// codes 6 and 7 select no target
	typedef enum logic [2:0] {
		RST_INT      = 3'd0,
		RST_SRAM     = 3'd1,
		RST_CDR      = 3'd2,
		RST_PRBS     = 3'd3,
		RST_PRBS_GEN = 3'd4,
		RST_ACORE    = 3'd5
	} rst_target_t;

endpackage

//--- src/jtag_reg_if.sv
`timescale 1ns/1ps

interface jtag_reg_if;

	// current instruction and scan strobes from the TAP
	debug_pkg::ir_t ir;
	logic           capture;
	logic           update;
	debug_pkg::dr_t shift_word;

	// read-back word, valid combinationally in the capture cycle
	debug_pkg::dr_t capture_word;

	modport tap (
		output ir,
		output capture,
		output update,
		output shift_word,
		input  capture_word
	);

	modport bank (
		input  ir,
		input  capture,
		input  update,
		input  shift_word,
		output capture_word
	);

endinterface

//--- src/jtag_pin_sync.sv
`timescale 1ns/1ps

module jtag_pin_sync #(
	parameter int SYNC_STAGES = 2
) (
	input  logic clk,
	input  logic rstb,
	input  logic tck_i,
	input  logic tms_i,
	input  logic tdi_i,
	input  logic trst_n_i,
	output logic tck_rise_o,
	output logic tck_fall_o,
	output logic tms_o,
	output logic tdi_o,
	output logic trst_n_o
);

	// pin order in each stage is trst_n, tdi, tms, tck
	logic [SYNC_STAGES-1:0][3:0] pin_q;
	logic [3:0]                  pin_s;
	logic                        tck_prev;

	// all stages clear low, so trst_n holds the TAP in reset until synced
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			pin_q <= '0;
		end else begin
			pin_q <= {pin_q[SYNC_STAGES-2:0], {trst_n_i, tdi_i, tms_i, tck_i}};
		end
	end

	assign pin_s = pin_q[SYNC_STAGES-1];

	// registered edge strobes, one clk behind the synced tck
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			tck_prev   <= 1'b0;
			tck_rise_o <= 1'b0;
			tck_fall_o <= 1'b0;
		end else begin
			tck_prev   <= pin_s[0];
			tck_rise_o <= pin_s[0] & ~tck_prev;
			tck_fall_o <= ~pin_s[0] & tck_prev;
		end
	end

	assign tms_o    = pin_s[1];
	assign tdi_o    = pin_s[2];
	assign trst_n_o = pin_s[3];

endmodule

//--- src/jtag_tap.sv
`timescale 1ns/1ps

module jtag_tap (
	input  logic       clk,
	input  logic       rstb,
	input  logic       tck_rise_i,
	input  logic       tck_fall_i,
	input  logic       tms_i,
	input  logic       tdi_i,
	input  logic       trst_n_i,
	jtag_reg_if.tap    reg_if,
	output logic       tdo_o
);

	// fixed pattern loaded in Capture-IR, LSBs 01 as the standard requires
	localparam debug_pkg::ir_t IR_CAPTURE = 5'b00001;

	debug_pkg::tap_state_t state_q;
	debug_pkg::tap_state_t state_next;
	debug_pkg::ir_t        ir_q;
	debug_pkg::ir_t        ir_shift;
	debug_pkg::dr_t        dr_shift;
	logic                  bypass_q;
	logic                  bypass_sel;
	logic                  capture_q;
	logic                  update_q;

	always_comb begin
		case (state_q)
			debug_pkg::TAP_TLR:      state_next = tms_i ? debug_pkg::TAP_TLR      : debug_pkg::TAP_RTI;
			debug_pkg::TAP_RTI:      state_next = tms_i ? debug_pkg::TAP_SEL_DR   : debug_pkg::TAP_RTI;
			debug_pkg::TAP_SEL_DR:   state_next = tms_i ? debug_pkg::TAP_SEL_IR   : debug_pkg::TAP_CAP_DR;
			debug_pkg::TAP_CAP_DR:   state_next = tms_i ? debug_pkg::TAP_EXIT1_DR : debug_pkg::TAP_SHIFT_DR;
			debug_pkg::TAP_SHIFT_DR: state_next = tms_i ? debug_pkg::TAP_EXIT1_DR : debug_pkg::TAP_SHIFT_DR;
			debug_pkg::TAP_EXIT1_DR: state_next = tms_i ? debug_pkg::TAP_UPD_DR   : debug_pkg::TAP_PAUSE_DR;
			debug_pkg::TAP_PAUSE_DR: state_next = tms_i ? debug_pkg::TAP_EXIT2_DR : debug_pkg::TAP_PAUSE_DR;
			debug_pkg::TAP_EXIT2_DR: state_next = tms_i ? debug_pkg::TAP_UPD_DR   : debug_pkg::TAP_SHIFT_DR;
			debug_pkg::TAP_UPD_DR:   state_next = tms_i ? debug_pkg::TAP_SEL_DR   : debug_pkg::TAP_RTI;
			debug_pkg::TAP_SEL_IR:   state_next = tms_i ? debug_pkg::TAP_TLR      : debug_pkg::TAP_CAP_IR;
			debug_pkg::TAP_CAP_IR:   state_next = tms_i ? debug_pkg::TAP_EXIT1_IR : debug_pkg::TAP_SHIFT_IR;
			debug_pkg::TAP_SHIFT_IR: state_next = tms_i ? debug_pkg::TAP_EXIT1_IR : debug_pkg::TAP_SHIFT_IR;
			debug_pkg::TAP_EXIT1_IR: state_next = tms_i ? debug_pkg::TAP_UPD_IR   : debug_pkg::TAP_PAUSE_IR;
			debug_pkg::TAP_PAUSE_IR: state_next = tms_i ? debug_pkg::TAP_EXIT2_IR : debug_pkg::TAP_PAUSE_IR;
			debug_pkg::TAP_EXIT2_IR: state_next = tms_i ? debug_pkg::TAP_UPD_IR   : debug_pkg::TAP_SHIFT_IR;
			debug_pkg::TAP_UPD_IR:   state_next = tms_i ? debug_pkg::TAP_SEL_DR   : debug_pkg::TAP_RTI;
			default:                 state_next = debug_pkg::TAP_TLR;
		endcase
	end

	// 1-bit bypass path for anything that is not a known instruction
	always_comb begin
		case (ir_q)
			debug_pkg::IR_IDCODE,
			debug_pkg::IR_CFG_CDR,
			debug_pkg::IR_CFG_IBUF,
			debug_pkg::IR_RSTB_CMD,
			debug_pkg::IR_STATUS: bypass_sel = 1'b0;
			default:              bypass_sel = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			state_q   <= debug_pkg::TAP_TLR;
			ir_q      <= debug_pkg::IR_IDCODE;
			capture_q <= 1'b0;
			update_q  <= 1'b0;
			tdo_o     <= 1'b0;
		end else if (!trst_n_i) begin
			state_q   <= debug_pkg::TAP_TLR;
			ir_q      <= debug_pkg::IR_IDCODE;
			capture_q <= 1'b0;
			update_q  <= 1'b0;
			tdo_o     <= 1'b0;
		end else begin
			// strobes are high the clk after the tck edge that enters the state
			capture_q <= tck_rise_i && (state_next == debug_pkg::TAP_CAP_DR);
			update_q  <= tck_rise_i && (state_next == debug_pkg::TAP_UPD_DR);
			if (tck_rise_i) begin
				state_q <= state_next;
				if (state_next == debug_pkg::TAP_TLR) begin
					ir_q <= debug_pkg::IR_IDCODE;
				end else if (state_next == debug_pkg::TAP_UPD_IR) begin
					ir_q <= ir_shift;
				end
			end
			if (tck_fall_i) begin
				if (state_q == debug_pkg::TAP_SHIFT_IR) begin
					tdo_o <= ir_shift[0];
				end else if (state_q == debug_pkg::TAP_SHIFT_DR) begin
					tdo_o <= bypass_sel ? bypass_q : dr_shift[0];
				end else begin
					tdo_o <= 1'b0;
				end
			end
		end
	end

	// scan shift registers, lsb first
	always_ff @(posedge clk) begin
		if (capture_q) begin
			dr_shift <= reg_if.capture_word;
			bypass_q <= 1'b0;
		end else if (tck_rise_i) begin
			case (state_q)
				debug_pkg::TAP_CAP_IR: ir_shift <= IR_CAPTURE;
				debug_pkg::TAP_SHIFT_IR: ir_shift <= {tdi_i, ir_shift[debug_pkg::IR_W-1:1]};
				debug_pkg::TAP_SHIFT_DR: begin
					dr_shift <= {tdi_i, dr_shift[debug_pkg::DR_W-1:1]};
					bypass_q <= tdi_i;
				end
				default: ;
			endcase
		end
	end

	assign reg_if.ir         = ir_q;
	assign reg_if.capture    = capture_q;
	assign reg_if.update     = update_q;
	assign reg_if.shift_word = dr_shift;

endmodule

//--- src/debug_reg_bank.sv
`timescale 1ns/1ps

module debug_reg_bank (
	input  logic                   clk,
	input  logic                   rstb,
	input  debug_pkg::pi_ctl_t     phase_est_i,
	jtag_reg_if.bank               reg_if,
	output debug_pkg::gain_t       ki_o,
	output debug_pkg::gain_t       kp_o,
	output debug_pkg::gain_t       kr_o,
	output logic                   en_ext_pi_ctl_o,
	output debug_pkg::pi_ctl_t     ext_pi_ctl_o,
	output logic                   disable_ibuf_async_o,
	output logic                   disable_ibuf_main_o,
	output logic                   disable_ibuf_mdll_ref_o,
	output logic                   disable_ibuf_mdll_mon_o,
	output debug_pkg::rst_target_t rst_sel_o,
	output logic                   rst_exec_o
);

	debug_pkg::gain_t       ki_q;
	debug_pkg::gain_t       kp_q;
	debug_pkg::gain_t       kr_q;
	logic                   en_ext_q;
	debug_pkg::pi_ctl_t     ext_pi_q;
	logic [3:0]             ibuf_dis_q;
	debug_pkg::rst_target_t rst_sel_q;
	logic                   rst_exec_q;

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			ki_q       <= '0;
			kp_q       <= '0;
			kr_q       <= '0;
			en_ext_q   <= 1'b0;
			ext_pi_q   <= '0;
			ibuf_dis_q <= '0;
			rst_sel_q  <= debug_pkg::RST_INT;
			rst_exec_q <= 1'b0;
		end else if (reg_if.update) begin
			// IDCODE, STATUS and bypass codes write nothing
			case (reg_if.ir)
				debug_pkg::IR_CFG_CDR: begin
					ki_q     <= reg_if.shift_word[3:0];
					kp_q     <= reg_if.shift_word[7:4];
					kr_q     <= reg_if.shift_word[11:8];
					en_ext_q <= reg_if.shift_word[12];
					ext_pi_q <= reg_if.shift_word[23:16];
				end
				debug_pkg::IR_CFG_IBUF: ibuf_dis_q <= reg_if.shift_word[3:0];
				debug_pkg::IR_RSTB_CMD: begin
					rst_sel_q  <= debug_pkg::rst_target_t'(reg_if.shift_word[2:0]);
					rst_exec_q <= reg_if.shift_word[3];
				end
				default: ;
			endcase
		end
	end

	// read-back, unused bits return zero
	always_comb begin
		case (reg_if.ir)
			debug_pkg::IR_IDCODE:   reg_if.capture_word = debug_pkg::IDCODE_VALUE;
			debug_pkg::IR_CFG_CDR:  reg_if.capture_word = {8'b0, ext_pi_q, 3'b0, en_ext_q,
			                                               kr_q, kp_q, ki_q};
			debug_pkg::IR_CFG_IBUF: reg_if.capture_word = {28'b0, ibuf_dis_q};
			debug_pkg::IR_RSTB_CMD: reg_if.capture_word = {28'b0, rst_exec_q, rst_sel_q};
			debug_pkg::IR_STATUS:   reg_if.capture_word = {23'b0, en_ext_q, phase_est_i};
			default:                reg_if.capture_word = '0;
		endcase
	end

	assign ki_o            = ki_q;
	assign kp_o            = kp_q;
	assign kr_o            = kr_q;
	assign en_ext_pi_ctl_o = en_ext_q;
	assign ext_pi_ctl_o    = ext_pi_q;

	assign disable_ibuf_async_o    = ibuf_dis_q[0];
	assign disable_ibuf_main_o     = ibuf_dis_q[1];
	assign disable_ibuf_mdll_ref_o = ibuf_dis_q[2];
	assign disable_ibuf_mdll_mon_o = ibuf_dis_q[3];

	assign rst_sel_o  = rst_sel_q;
	assign rst_exec_o = rst_exec_q;

endmodule

//--- src/reset_toggle_ctrl.sv
`timescale 1ns/1ps

module reset_toggle_ctrl (
	input  logic                   clk,
	input  logic                   rstb,
	input  debug_pkg::rst_target_t rst_sel_i,
	input  logic                   rst_exec_i,
	output logic                   int_rstb_o,
	output logic                   sram_rstb_o,
	output logic                   cdr_rstb_o,
	output logic                   prbs_rstb_o,
	output logic                   prbs_gen_rstb_o,
	output logic                   acore_rstb_o
);

	// acore comes out of reset released, the rest held
	localparam logic [debug_pkg::RST_TARGETS-1:0] TGL_INIT = 6'b10_0000;

	logic [debug_pkg::RST_TARGETS-1:0] tgl_q;
	logic [debug_pkg::RST_TARGETS-1:0] sel_hot;
	logic                              exec_prev;
	logic                              exec_rise;

	assign exec_rise = rst_exec_i & ~exec_prev;

	always_comb begin
		sel_hot = '0;
		if (exec_rise) begin
			case (rst_sel_i)
				debug_pkg::RST_INT:      sel_hot[0] = 1'b1;
				debug_pkg::RST_SRAM:     sel_hot[1] = 1'b1;
				debug_pkg::RST_CDR:      sel_hot[2] = 1'b1;
				debug_pkg::RST_PRBS:     sel_hot[3] = 1'b1;
				debug_pkg::RST_PRBS_GEN: sel_hot[4] = 1'b1;
				debug_pkg::RST_ACORE:    sel_hot[5] = 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			tgl_q     <= TGL_INIT;
			exec_prev <= 1'b0;
		end else begin
			tgl_q     <= tgl_q ^ sel_hot;
			exec_prev <= rst_exec_i;
		end
	end

	// every line also follows the chip reset
	assign int_rstb_o      = tgl_q[0] & rstb;
	assign sram_rstb_o     = tgl_q[1] & rstb;
	assign cdr_rstb_o      = tgl_q[2] & rstb;
	assign prbs_rstb_o     = tgl_q[3] & rstb;
	assign prbs_gen_rstb_o = tgl_q[4] & rstb;
	assign acore_rstb_o    = tgl_q[5] & rstb;

endmodule

//--- src/debug_jtag_top.sv
`timescale 1ns/1ps

module debug_jtag_top #(
	parameter int SYNC_STAGES = 2
) (
	input  logic               clk,
	input  logic               rstb,
	input  logic               tck_i,
	input  logic               tms_i,
	input  logic               tdi_i,
	input  logic               trst_n_i,
	input  debug_pkg::pi_ctl_t phase_est_i,
	output logic               tdo_o,
	output logic               int_rstb_o,
	output logic               sram_rstb_o,
	output logic               cdr_rstb_o,
	output logic               prbs_rstb_o,
	output logic               prbs_gen_rstb_o,
	output logic               acore_rstb_o,
	output logic               disable_ibuf_async_o,
	output logic               disable_ibuf_main_o,
	output logic               disable_ibuf_mdll_ref_o,
	output logic               disable_ibuf_mdll_mon_o,
	output debug_pkg::gain_t   ki_o,
	output debug_pkg::gain_t   kp_o,
	output debug_pkg::gain_t   kr_o,
	output logic               en_ext_pi_ctl_o,
	output debug_pkg::pi_ctl_t ext_pi_ctl_o
);

	logic                   tck_rise;
	logic                   tck_fall;
	logic                   tms_s;
	logic                   tdi_s;
	logic                   trst_n_s;
	debug_pkg::rst_target_t rst_sel;
	logic                   rst_exec;

	jtag_reg_if reg_if ();

	jtag_pin_sync #(
		.SYNC_STAGES(SYNC_STAGES)
	) u_pin_sync (
		.clk        (clk),
		.rstb       (rstb),
		.tck_i      (tck_i),
		.tms_i      (tms_i),
		.tdi_i      (tdi_i),
		.trst_n_i   (trst_n_i),
		.tck_rise_o (tck_rise),
		.tck_fall_o (tck_fall),
		.tms_o      (tms_s),
		.tdi_o      (tdi_s),
		.trst_n_o   (trst_n_s)
	);

	jtag_tap u_tap (
		.clk        (clk),
		.rstb       (rstb),
		.tck_rise_i (tck_rise),
		.tck_fall_i (tck_fall),
		.tms_i      (tms_s),
		.tdi_i      (tdi_s),
		.trst_n_i   (trst_n_s),
		.reg_if     (reg_if),
		.tdo_o      (tdo_o)
	);

	debug_reg_bank u_reg_bank (
		.clk                     (clk),
		.rstb                    (rstb),
		.phase_est_i             (phase_est_i),
		.reg_if                  (reg_if),
		.ki_o                    (ki_o),
		.kp_o                    (kp_o),
		.kr_o                    (kr_o),
		.en_ext_pi_ctl_o         (en_ext_pi_ctl_o),
		.ext_pi_ctl_o            (ext_pi_ctl_o),
		.disable_ibuf_async_o    (disable_ibuf_async_o),
		.disable_ibuf_main_o     (disable_ibuf_main_o),
		.disable_ibuf_mdll_ref_o (disable_ibuf_mdll_ref_o),
		.disable_ibuf_mdll_mon_o (disable_ibuf_mdll_mon_o),
		.rst_sel_o               (rst_sel),
		.rst_exec_o              (rst_exec)
	);

	reset_toggle_ctrl u_rst_ctrl (
		.clk             (clk),
		.rstb            (rstb),
		.rst_sel_i       (rst_sel),
		.rst_exec_i      (rst_exec),
		.int_rstb_o      (int_rstb_o),
		.sram_rstb_o     (sram_rstb_o),
		.cdr_rstb_o      (cdr_rstb_o),
		.prbs_rstb_o     (prbs_rstb_o),
		.prbs_gen_rstb_o (prbs_gen_rstb_o),
		.acore_rstb_o    (acore_rstb_o)
	);

endmodule

//--- verification/tb_jtag_tasks.svh
// tck runs at one eighth of the clk rate, 4 clk low then 4 clk high.
// Every call starts and ends 2 ns after a rising clk edge.

task automatic wait_clks(input int n);
	repeat (n) @(posedge clk);
	#2;
endtask

// one tck period, the falling edge first, so tdo is sampled just before the rise
task automatic pulse_tck(input logic tms, input logic tdi, output logic tdo);
	tck_i = 1'b0;
	tms_i = tms;
	tdi_i = tdi;
	wait_clks(4);
	tdo = tdo_o;
	tck_i = 1'b1;
	wait_clks(4);
endtask

// from Test-Logic-Reset to Run-Test/Idle
task automatic go_idle();
	logic tdo;
	pulse_tck(1'b0, 1'b0, tdo);
endtask

// five tms-high cycles reach Test-Logic-Reset from any state
task automatic reset_tap();
	logic tdo;
	repeat (5) pulse_tck(1'b1, 1'b0, tdo);
	go_idle();
endtask

task automatic pulse_trst();
	trst_n_i = 1'b0;
	wait_clks(8);
	trst_n_i = 1'b1;
	wait_clks(4);
	go_idle();
endtask

// instruction scan from Run-Test/Idle back to Run-Test/Idle
task automatic scan_ir(input debug_pkg::ir_t ir);
	logic           tdo;
	debug_pkg::ir_t bits;
	bits = ir;
	pulse_tck(1'b1, 1'b0, tdo);
	pulse_tck(1'b1, 1'b0, tdo);
	pulse_tck(1'b0, 1'b0, tdo);
	pulse_tck(1'b0, 1'b0, tdo);
	for (int i = 0; i < 5; i++) begin
		pulse_tck(i == 4, bits[0], tdo);
		bits = bits >> 1;
	end
	pulse_tck(1'b1, 1'b0, tdo);
	pulse_tck(1'b0, 1'b0, tdo);
endtask

// 32-bit data scan, lsb first, returns the captured word
task automatic scan_dr(input debug_pkg::dr_t wr, output debug_pkg::dr_t rd);
	logic           tdo;
	debug_pkg::dr_t bits;
	bits = wr;
	rd = '0;
	pulse_tck(1'b1, 1'b0, tdo);
	pulse_tck(1'b0, 1'b0, tdo);
	pulse_tck(1'b0, 1'b0, tdo);
	for (int i = 0; i < 32; i++) begin
		pulse_tck(i == 31, bits[0], tdo);
		rd = {tdo, rd[31:1]};
		bits = bits >> 1;
	end
	pulse_tck(1'b1, 1'b0, tdo);
	pulse_tck(1'b0, 1'b0, tdo);
endtask

function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1103515245 + 32'd12345;
endfunction

//--- verification/tb_debug_jtag.sv
`timescale 1ns/1ps

module tb_debug_jtag;

	localparam debug_pkg::dr_t IDCODE_EXP   = 32'h1A5C_0001;
	localparam int             SETTLE_LIMIT = 200;

	// vec layout: [39:16] cdr word bits 23..0, [11:8] ibuf disables, [5:0] reset lines
	typedef struct packed {
		debug_pkg::ir_t ir;
		debug_pkg::dr_t wr;
		debug_pkg::dr_t rd;
		logic [39:0]    vec;
	} row_t;

	logic               clk;
	logic               rstb;
	logic               tck_i;
	logic               tms_i;
	logic               tdi_i;
	logic               trst_n_i;
	debug_pkg::pi_ctl_t phase_est_i;
	logic               tdo_o;
	logic [5:0]         rst_lines;
	logic [3:0]         ibuf_dis;
	debug_pkg::gain_t   ki_o;
	debug_pkg::gain_t   kp_o;
	debug_pkg::gain_t   kr_o;
	logic               en_ext_pi_ctl_o;
	debug_pkg::pi_ctl_t ext_pi_ctl_o;
	logic [39:0]        out_vec;

	row_t rows[$];
	int   mismatches;
	int   tests_run;
	int   tests_bad;

	assign out_vec = {ext_pi_ctl_o, 3'b0, en_ext_pi_ctl_o, kr_o, kp_o, ki_o,
	                  4'h0, ibuf_dis, 2'b0, rst_lines};

	always #20 clk = ~clk;

	debug_jtag_top #(
		.SYNC_STAGES(2)
	) uut (
		.clk                     (clk),
		.rstb                    (rstb),
		.tck_i                   (tck_i),
		.tms_i                   (tms_i),
		.tdi_i                   (tdi_i),
		.trst_n_i                (trst_n_i),
		.phase_est_i             (phase_est_i),
		.tdo_o                   (tdo_o),
		.int_rstb_o              (rst_lines[0]),
		.sram_rstb_o             (rst_lines[1]),
		.cdr_rstb_o              (rst_lines[2]),
		.prbs_rstb_o             (rst_lines[3]),
		.prbs_gen_rstb_o         (rst_lines[4]),
		.acore_rstb_o            (rst_lines[5]),
		.disable_ibuf_async_o    (ibuf_dis[0]),
		.disable_ibuf_main_o     (ibuf_dis[1]),
		.disable_ibuf_mdll_ref_o (ibuf_dis[2]),
		.disable_ibuf_mdll_mon_o (ibuf_dis[3]),
		.ki_o                    (ki_o),
		.kp_o                    (kp_o),
		.kr_o                    (kr_o),
		.en_ext_pi_ctl_o         (en_ext_pi_ctl_o),
		.ext_pi_ctl_o            (ext_pi_ctl_o)
	);

	`include "tb_jtag_tasks.svh"

	task automatic flag_mismatch(input string what, input logic [63:0] got,
	                             input logic [63:0] exp);
		mismatches++;
		$display("FAIL %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
	endtask

	task automatic wait_outputs(input logic [39:0] exp);
		int cycles;
		cycles = 0;
		while (out_vec !== exp && cycles < SETTLE_LIMIT) begin
			wait_clks(1);
			cycles++;
		end
		if (out_vec !== exp)
			flag_mismatch("outputs not settled after 200 clk", {24'h0, out_vec}, {24'h0, exp});
	endtask

	task automatic close_test(input string name, input int errs_before);
		tests_run++;
		if (mismatches != errs_before) begin
			tests_bad++;
			$display("test %s: had mismatches", name);
		end else begin
			$display("test %s: passed", name);
		end
	endtask

	function automatic void add_row(input debug_pkg::ir_t ir, input debug_pkg::dr_t wr,
	                                input debug_pkg::dr_t rd, input logic [39:0] vec);
		row_t r;
		r.ir = ir;
		r.wr = wr;
		r.rd = rd;
		r.vec = vec;
		rows.push_back(r);
	endfunction

	initial begin
		debug_pkg::dr_t rd;
		debug_pkg::dr_t pat;
		debug_pkg::dr_t cdr_word;
		debug_pkg::ir_t code;
		logic [39:0]    cur_vec;
		logic [31:0]    lcg_state;
		int             errs_before;

		clk = 1'b0;
		rstb = 1'b0;
		tck_i = 1'b0;
		tms_i = 1'b0;
		tdi_i = 1'b0;
		trst_n_i = 1'b1;
		phase_est_i = '0;
		mismatches = 0;
		tests_run = 0;
		tests_bad = 0;
		lcg_state = 32'd6;
		cdr_word = '0;
		cur_vec = 40'h00_0000_0020;

		// cdr fields, bits 15..13 and 31..24 read back as zero
		add_row(debug_pkg::IR_CFG_CDR, 32'hFFFF_FFFF, 32'h00FF_1FFF, 40'hFF1FFF0020);
		add_row(debug_pkg::IR_CFG_CDR, 32'h0000_0000, 32'h0000_0000, 40'h0000000020);
		add_row(debug_pkg::IR_CFG_CDR, 32'h1234_0987, 32'h0034_0987, 40'h3409870020);
		add_row(debug_pkg::IR_CFG_CDR, 32'hA5E3_5A7C, 32'h00E3_1A7C, 40'hE31A7C0020);
		add_row(debug_pkg::IR_CFG_IBUF, 32'hFFFF_FFF5, 32'h0000_0005, 40'hE31A7C0520);
		add_row(debug_pkg::IR_CFG_IBUF, 32'h0000_000A, 32'h0000_000A, 40'hE31A7C0A20);
		// each target: execute clear, then set, flips one line
		add_row(debug_pkg::IR_RSTB_CMD, 32'h0, 32'h0, 40'hE31A7C0A20);
		add_row(debug_pkg::IR_RSTB_CMD, 32'h8, 32'h8, 40'hE31A7C0A21);
		add_row(debug_pkg::IR_RSTB_CMD, 32'h1, 32'h1, 40'hE31A7C0A21);
		add_row(debug_pkg::IR_RSTB_CMD, 32'h9, 32'h9, 40'hE31A7C0A23);
		add_row(debug_pkg::IR_RSTB_CMD, 32'h2, 32'h2, 40'hE31A7C0A23);
		add_row(debug_pkg::IR_RSTB_CMD, 32'hA, 32'hA, 40'hE31A7C0A27);
		add_row(debug_pkg::IR_RSTB_CMD, 32'h3, 32'h3, 40'hE31A7C0A27);
		add_row(debug_pkg::IR_RSTB_CMD, 32'hB, 32'hB, 40'hE31A7C0A2F);
		add_row(debug_pkg::IR_RSTB_CMD, 32'h4, 32'h4, 40'hE31A7C0A2F);
		add_row(debug_pkg::IR_RSTB_CMD, 32'hC, 32'hC, 40'hE31A7C0A3F);
		add_row(debug_pkg::IR_RSTB_CMD, 32'h5, 32'h5, 40'hE31A7C0A3F);
		add_row(debug_pkg::IR_RSTB_CMD, 32'hD, 32'hD, 40'hE31A7C0A1F);
		// held execute bit, then codes 6 and 7 with no target
		add_row(debug_pkg::IR_RSTB_CMD, 32'hD, 32'hD, 40'hE31A7C0A1F);
		add_row(debug_pkg::IR_RSTB_CMD, 32'h6, 32'h6, 40'hE31A7C0A1F);
		add_row(debug_pkg::IR_RSTB_CMD, 32'hE, 32'hE, 40'hE31A7C0A1F);
		add_row(debug_pkg::IR_RSTB_CMD, 32'h7, 32'h7, 40'hE31A7C0A1F);
		add_row(debug_pkg::IR_RSTB_CMD, 32'hF, 32'hF, 40'hE31A7C0A1F);

		errs_before = mismatches;
		repeat (15) @(posedge clk);
		#2;
		if (out_vec !== 40'h0)
			flag_mismatch("outputs during reset", {24'h0, out_vec}, 64'h0);
		@(posedge clk);
		#2;
		rstb = 1'b1;
		wait_clks(1);
		if (out_vec !== cur_vec)
			flag_mismatch("outputs after reset", {24'h0, out_vec}, {24'h0, cur_vec});
		if (tdo_o !== 1'b0)
			flag_mismatch("tdo after reset", {63'h0, tdo_o}, 64'h0);
		close_test("reset values", errs_before);

		errs_before = mismatches;
		go_idle();
		scan_dr(32'h0, rd);
		if (rd !== IDCODE_EXP)
			flag_mismatch("idcode after reset", {32'h0, rd}, {32'h0, IDCODE_EXP});
		close_test("idcode after reset", errs_before);

		for (int n = 0; n < rows.size(); n++) begin
			errs_before = mismatches;
			scan_ir(rows[n].ir);
			scan_dr(rows[n].wr, rd);
			wait_outputs(rows[n].vec);
			scan_dr(rows[n].wr, rd);
			if (rd !== rows[n].rd)
				flag_mismatch("read-back word", {32'h0, rd}, {32'h0, rows[n].rd});
			wait_outputs(rows[n].vec);
			cur_vec = rows[n].vec;
			if (rows[n].ir == debug_pkg::IR_CFG_CDR)
				cdr_word = rows[n].wr;
			close_test($sformatf("row %0d ir %0d", n, rows[n].ir), errs_before);
		end

		errs_before = mismatches;
		scan_ir(debug_pkg::IR_STATUS);
		for (int k = 0; k < 4; k++) begin
			lcg_state = lcg_next(lcg_state);
			phase_est_i = lcg_state[23:16];
			scan_dr(32'h0, rd);
			if (rd !== {23'h0, cdr_word[12], phase_est_i})
				flag_mismatch("status word", {32'h0, rd},
				              {32'h0, 23'h0, cdr_word[12], phase_est_i});
		end
		wait_outputs(cur_vec);
		close_test("status capture", errs_before);

		// 0x0B is not a known instruction and must act as bypass
		errs_before = mismatches;
		for (int k = 0; k < 2; k++) begin
			code = (k == 0) ? debug_pkg::IR_BYPASS : 5'h0B;
			scan_ir(code);
			lcg_state = lcg_next(lcg_state);
			pat = lcg_state;
			scan_dr(pat, rd);
			if (rd !== {pat[30:0], 1'b0})
				flag_mismatch("bypass tdo", {32'h0, rd}, {32'h0, pat[30:0], 1'b0});
		end
		wait_outputs(cur_vec);
		close_test("bypass", errs_before);

		errs_before = mismatches;
		scan_ir(debug_pkg::IR_CFG_CDR);
		reset_tap();
		scan_dr(32'h0, rd);
		if (rd !== IDCODE_EXP)
			flag_mismatch("idcode after tms reset", {32'h0, rd}, {32'h0, IDCODE_EXP});
		wait_outputs(cur_vec);
		close_test("tap reset by tms", errs_before);

		errs_before = mismatches;
		scan_ir(debug_pkg::IR_CFG_IBUF);
		pulse_trst();
		scan_dr(32'h0, rd);
		if (rd !== IDCODE_EXP)
			flag_mismatch("idcode after trst", {32'h0, rd}, {32'h0, IDCODE_EXP});
		wait_outputs(cur_vec);
		close_test("tap reset by trst", errs_before);

		$display("tests run %0d, tests with mismatches %0d, mismatches %0d",
		         tests_run, tests_bad, mismatches);
		if (mismatches == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- debug_jtag.f
src/debug_pkg.sv
src/jtag_reg_if.sv
src/jtag_pin_sync.sv
src/jtag_tap.sv
src/debug_reg_bank.sv
src/reset_toggle_ctrl.sv
src/debug_jtag_top.sv
+incdir+verification
verification/tb_debug_jtag.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the JTAG debug controller testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --top-module tb_debug_jtag -f debug_jtag.f -o sim_debug_jtag

./obj_dir/sim_debug_jtag | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
	echo "testbench reported errors, see $LOG"
	exit 1
fi
echo "testbench run clean"
